//--- design/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'h8000_0000

// icache geometry
// 16 lines of 4 words, direct mapped
`define ICACHE_LINES 16
`define ICACHE_LINE_WORDS 4

// decode buffer depth
// one credit per free decode slot
`define FETCH_CREDITS 4

// backing word memory size
`define MEM_WORDS 1024

// cycles from read grant to read data
`define MEM_LATENCY 2

`endif

//--- design/fetch_pkg.sv
package fetch_pkg;

  // payload handed to decode
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_packet_t;

  // jump or trap redirect from the back end
  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

  // memory request, shared by both arbiter clients and the memory
  // addr is a word address, not a byte address
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  // read response
  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } mem_rsp_t;

  // icache refill states
  typedef enum logic [1:0] {
    CACHE_IDLE,
    CACHE_REFILL,
    CACHE_FILL_WAIT
  } cache_state_t;

  // opcode classes that matter to prediction
  typedef enum logic {
    BR_NONE,
    BR_COND
  } branch_class_t;

endpackage

//--- design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     fencei,
  input  logic                     credit_return,
  input  fetch_pkg::redirect_t     redirect,
  input  fetch_pkg::mem_req_t      store_req,
  output logic                     store_gnt,
  output fetch_pkg::fetch_packet_t packet,
  output logic                     packet_valid
);

  logic [31:0]         fetch_pc;
  logic                hit;
  logic [31:0]         inst;
  fetch_pkg::mem_req_t refill_req;
  logic                refill_gnt;
  fetch_pkg::mem_rsp_t refill_rsp;
  fetch_pkg::mem_req_t mem_req;
  fetch_pkg::mem_rsp_t mem_rsp;

  fetch_unit fetch_unit_inst (
    .clock(clock), .reset(reset), .redirect(redirect), .credit_return(credit_return),
    .hit(hit), .inst(inst), .fetch_pc(fetch_pc), .packet(packet),
    .packet_valid(packet_valid)
  );

  icache icache_inst (
    .clock(clock), .reset(reset), .fencei(fencei), .addr(fetch_pc), .hit(hit),
    .inst(inst), .refill_req(refill_req), .refill_gnt(refill_gnt), .refill_rsp(refill_rsp)
  );

  // refill and store share the memory
  mem_arbiter mem_arbiter_inst (
    .clock(clock), .reset(reset), .refill_req(refill_req), .store_req(store_req),
    .refill_gnt(refill_gnt), .store_gnt(store_gnt), .refill_rsp(refill_rsp),
    .mem_req(mem_req), .mem_rsp(mem_rsp)
  );

  word_memory word_memory_inst (
    .clock(clock), .reset(reset), .mem_req(mem_req), .mem_rsp(mem_rsp)
  );

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_unit (
  input  logic                     clock,
  input  logic                     reset,
  input  fetch_pkg::redirect_t     redirect,
  input  logic                     credit_return,
  input  logic                     hit,
  input  logic [31:0]              inst,
  output logic [31:0]              fetch_pc,
  output fetch_pkg::fetch_packet_t packet,
  output logic                     packet_valid
);

  // major opcode of conditional branches (inst[6:2])
  localparam logic [4:0] OPC_BRANCH = 5'b11000;
  // counter must hold 0 .. FETCH_CREDITS
  localparam int CW = $clog2(`FETCH_CREDITS + 1);

  logic [31:0]              fetch_pc_q;
  fetch_pkg::redirect_t     pending_q;
  logic [CW-1:0]            credits_q;
  fetch_pkg::fetch_packet_t packet_q;
  logic                     packet_valid_q;

  fetch_pkg::branch_class_t br_class;
  logic [31:0]              imm_b;
  logic [31:0]              pred_pc;
  logic                     redirecting;
  logic [31:0]              redirect_pc;
  logic                     send;

  // classify the word currently coming out of the cache
  always_comb begin
    if (inst[6:2] == OPC_BRANCH) begin
      br_class = fetch_pkg::BR_COND;
    end else begin
      br_class = fetch_pkg::BR_NONE;
    end
  end

  // b-type immediate, bit 0 always zero
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

  // static prediction
  // backward branch taken, everything else falls through
  assign pred_pc = (br_class == fetch_pkg::BR_COND && imm_b[31]) ?
                   fetch_pc_q + imm_b : fetch_pc_q + 32'd4;

  // a live redirect beats one already waiting
  assign redirecting = redirect.valid | pending_q.valid;
  assign redirect_pc = redirect.valid ? redirect.target : pending_q.target;

  // no packet while a redirect is active or pending
  assign send = hit & (credits_q != '0) & ~redirecting;

  // fetch pc and pending redirect
  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_pc_q      <= `FETCH_RESET_PC;
      pending_q.valid <= 1'b0;
    end else if (redirecting) begin
      if (hit) begin
        // cache is settled, take the target now
        fetch_pc_q      <= redirect_pc;
        pending_q.valid <= 1'b0;
      end else begin
        // refill in flight, park the target until a hit
        pending_q.valid <= 1'b1;
      end
    end else if (send) begin
      fetch_pc_q <= pred_pc;
    end
  end

  // pending target is payload only
  always_ff @(posedge clock) begin
    if (redirect.valid) begin
      pending_q.target <= redirect.target;
    end
  end

  // credit counter
  // send and return may land in the same cycle and cancel out
  always_ff @(posedge clock) begin
    if (reset) begin
      credits_q <= CW'(`FETCH_CREDITS);
    end else begin
      case ({send, credit_return})
        2'b10: credits_q <= credits_q - 1'b1;
        2'b01: begin
          // saturate at the decode buffer depth
          if (credits_q != CW'(`FETCH_CREDITS)) begin
            credits_q <= credits_q + 1'b1;
          end
        end
        default: begin
          credits_q <= credits_q;
        end
      endcase
    end
  end

  // registered packet, one cycle valid per send
  always_ff @(posedge clock) begin
    if (reset) begin
      packet_valid_q <= 1'b0;
    end else begin
      packet_valid_q <= send;
    end
  end

  always_ff @(posedge clock) begin
    if (send) begin
      packet_q.pc   <= fetch_pc_q;
      packet_q.inst <= inst;
    end
  end

  assign fetch_pc     = fetch_pc_q;
  assign packet       = packet_q;
  assign packet_valid = packet_valid_q;

endmodule

//--- design/icache.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module icache (
  input  logic                clock,
  input  logic                reset,
  input  logic                fencei,
  input  logic [31:0]         addr,
  output logic                hit,
  output logic [31:0]         inst,
  output fetch_pkg::mem_req_t refill_req,
  input  logic                refill_gnt,
  input  fetch_pkg::mem_rsp_t refill_rsp
);

  // byte address split: tag | index | word | 2'b00
  localparam int WORD_BITS  = $clog2(`ICACHE_LINE_WORDS);
  localparam int INDEX_BITS = $clog2(`ICACHE_LINES);
  localparam int INDEX_LSB  = 2 + WORD_BITS;
  localparam int TAG_LSB    = INDEX_LSB + INDEX_BITS;
  localparam int TAG_BITS   = 32 - TAG_LSB;

  logic [TAG_BITS-1:0]    tag_q  [`ICACHE_LINES];
  logic [31:0]            data_q [`ICACHE_LINES][`ICACHE_LINE_WORDS];
  logic [`ICACHE_LINES-1:0] valid_q;

  fetch_pkg::cache_state_t state_q;
  // line being refilled, word aligned part above the line offset
  logic [31:INDEX_LSB]    line_q;
  logic [WORD_BITS-1:0]   cnt_q;
  // fence.i seen mid-refill, line must not become valid
  logic                   stale_q;

  logic [INDEX_BITS-1:0]  idx;
  logic [WORD_BITS-1:0]   word;
  logic [TAG_BITS-1:0]    tag;
  logic [INDEX_BITS-1:0]  fill_idx;
  logic                   start;
  logic                   fill;
  logic                   fill_last;

  assign idx  = addr[TAG_LSB-1:INDEX_LSB];
  assign word = addr[INDEX_LSB-1:2];
  assign tag  = addr[31:TAG_LSB];

  // zero latency lookup
  assign hit  = valid_q[idx] && (tag_q[idx] == tag);
  assign inst = data_q[idx][word];

  assign fill_idx  = line_q[TAG_LSB-1:INDEX_LSB];
  assign start     = (state_q == fetch_pkg::CACHE_IDLE) && !hit;
  assign fill      = (state_q == fetch_pkg::CACHE_FILL_WAIT) && refill_rsp.valid;
  assign fill_last = fill && (cnt_q == WORD_BITS'(`ICACHE_LINE_WORDS - 1));

  // one word read per request, held until granted
  always_comb begin
    refill_req.valid = (state_q == fetch_pkg::CACHE_REFILL);
    refill_req.write = 1'b0;
    refill_req.addr  = {2'b00, line_q, cnt_q};
    refill_req.wdata = '0;
  end

  // refill FSM
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= fetch_pkg::CACHE_IDLE;
      stale_q <= 1'b0;
    end else begin
      case (state_q)
        fetch_pkg::CACHE_IDLE: begin
          if (start) begin
            state_q <= fetch_pkg::CACHE_REFILL;
            stale_q <= 1'b0;
          end
        end
        fetch_pkg::CACHE_REFILL: begin
          if (refill_gnt) begin
            state_q <= fetch_pkg::CACHE_FILL_WAIT;
          end
        end
        fetch_pkg::CACHE_FILL_WAIT: begin
          if (fill_last) begin
            state_q <= fetch_pkg::CACHE_IDLE;
          end else if (fill) begin
            state_q <= fetch_pkg::CACHE_REFILL;
          end
        end
        default: begin
          state_q <= fetch_pkg::CACHE_IDLE;
        end
      endcase
      if (fencei && state_q != fetch_pkg::CACHE_IDLE) begin
        stale_q <= 1'b1;
      end
    end
  end

  // line base and word counter
  always_ff @(posedge clock) begin
    if (start) begin
      line_q <= addr[31:INDEX_LSB];
      cnt_q  <= '0;
    end else if (fill) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // tag goes in at refill start, line already invalidated then
  always_ff @(posedge clock) begin
    if (start) begin
      tag_q[idx] <= tag;
    end
    if (fill) begin
      data_q[fill_idx][cnt_q] <= refill_rsp.rdata;
    end
  end

  // valid bits
  // fence.i clears everything in one cycle
  always_ff @(posedge clock) begin
    if (reset || fencei) begin
      valid_q <= '0;
    end else if (start) begin
      valid_q[idx] <= 1'b0;
    end else if (fill_last && !stale_q) begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

endmodule

//--- design/mem_arbiter.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module mem_arbiter (
  input  logic                clock,
  input  logic                reset,
  input  fetch_pkg::mem_req_t refill_req,
  input  fetch_pkg::mem_req_t store_req,
  output logic                refill_gnt,
  output logic                store_gnt,
  output fetch_pkg::mem_rsp_t refill_rsp,
  output fetch_pkg::mem_req_t mem_req,
  input  fetch_pkg::mem_rsp_t mem_rsp
);

  // last winner, 1 means the store port won last
  logic                    last_store_q;
  // marks reads in flight that belong to the refill port
  logic [`MEM_LATENCY-1:0] refill_rd_q;

  // round robin
  // the client that lost last time has priority on a tie
  assign refill_gnt = refill_req.valid & (~store_req.valid | last_store_q);
  assign store_gnt  = store_req.valid & (~refill_req.valid | ~last_store_q);

  always_comb begin
    mem_req = '0;
    if (refill_gnt) begin
      mem_req = refill_req;
    end else if (store_gnt) begin
      mem_req = store_req;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      last_store_q <= 1'b0;
    end else if (refill_gnt | store_gnt) begin
      last_store_q <= store_gnt;
    end
  end

  // track refill reads through the memory latency
  always_ff @(posedge clock) begin
    if (reset) begin
      refill_rd_q <= '0;
    end else begin
      refill_rd_q[0] <= refill_gnt & ~refill_req.write;
      for (int i = 1; i < `MEM_LATENCY; i++) begin
        refill_rd_q[i] <= refill_rd_q[i-1];
      end
    end
  end

  // responses only go back to the cache
  assign refill_rsp.valid = mem_rsp.valid & refill_rd_q[`MEM_LATENCY-1];
  assign refill_rsp.rdata = mem_rsp.rdata;

endmodule

//--- design/word_memory.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module word_memory (
  input  logic                clock,
  input  logic                reset,
  input  fetch_pkg::mem_req_t mem_req,
  output fetch_pkg::mem_rsp_t mem_rsp
);

  localparam int AW = $clog2(`MEM_WORDS);

  logic [31:0]         mem [`MEM_WORDS];
  // read pipeline, stage 0 loads in the grant cycle
  fetch_pkg::mem_rsp_t pipe_q [`MEM_LATENCY];

  logic [AW-1:0]       idx;
  logic                rd;

  // word address wraps at the memory size
  assign idx = mem_req.addr[AW-1:0];
  assign rd  = mem_req.valid & ~mem_req.write;

  // writes land on the grant edge
  always_ff @(posedge clock) begin
    if (mem_req.valid && mem_req.write) begin
      mem[idx] <= mem_req.wdata;
    end
  end

  // read data shifts along with its valid
  always_ff @(posedge clock) begin
    pipe_q[0].rdata <= mem[idx];
    for (int i = 1; i < `MEM_LATENCY; i++) begin
      pipe_q[i].rdata <= pipe_q[i-1].rdata;
    end
  end

  // several reads may be in flight at once
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `MEM_LATENCY; i++) begin
        pipe_q[i].valid <= 1'b0;
      end
    end else begin
      pipe_q[0].valid <= rd;
      for (int i = 1; i < `MEM_LATENCY; i++) begin
        pipe_q[i].valid <= pipe_q[i-1].valid;
      end
    end
  end

  assign mem_rsp = pipe_q[`MEM_LATENCY-1];

endmodule

//--- filelist.f
+incdir+design
design/fetch_pkg.sv
design/fetch_unit.sv
design/icache.sv
design/mem_arbiter.sv
design/word_memory.sv
design/fetch_top.sv
tests/fetch_properties.sv
tests/fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fetch_tb -f filelist.f \
  -o fetch_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log

grep -qx "Test passed" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }

//--- tests/fetch_properties.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_properties (
  input logic clock,
  input logic reset,
  input logic refill_valid,
  input logic store_valid,
  input logic refill_gnt,
  input logic store_gnt,
  input logic packet_valid,
  input logic credit_return
);

  // cycles a request has waited without a grant
  logic [3:0] refill_wait_q;
  logic [3:0] store_wait_q;
  // free decode slots as seen from the decode side
  logic [3:0] free_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      refill_wait_q <= '0;
      store_wait_q  <= '0;
    end else begin
      refill_wait_q <= (refill_valid && !refill_gnt) ? refill_wait_q + 1'b1 : '0;
      store_wait_q  <= (store_valid && !store_gnt) ? store_wait_q + 1'b1 : '0;
    end
  end

  // packets take a slot, returns give one back
  always_ff @(posedge clock) begin
    if (reset) begin
      free_q <= 4'(`FETCH_CREDITS);
    end else begin
      free_q <= free_q - {3'b000, packet_valid} + {3'b000, credit_return};
    end
  end

  // one memory client per cycle
  one_grant: assert property (@(posedge clock) disable iff (reset)
    !(refill_gnt && store_gnt)) else $error("both memory clients granted");

  // round robin bounds the wait to a couple of cycles
  refill_served: assert property (@(posedge clock) disable iff (reset)
    refill_wait_q < 4'd4) else $error("refill request starved");
  store_served: assert property (@(posedge clock) disable iff (reset)
    store_wait_q < 4'd4) else $error("store request starved");

  // a packet needs a free decode slot when it arrives
  credit_held: assert property (@(posedge clock) disable iff (reset)
    packet_valid |-> free_q != '0) else $error("packet sent without credit");

endmodule

//--- tests/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_tb;

  typedef enum logic [2:0] {K_STORE, K_RUN, K_REDIRECT, K_FENCEI, K_CREDIT} kind_t;
  typedef struct packed {
    kind_t       kind;
    logic [31:0] a;
    logic [31:0] b;
  } entry_t;

  // region R holds a forward branch, a plain word and a backward branch
  localparam logic [31:0] R_PC = `FETCH_RESET_PC + 32'h400;
  localparam logic [31:0] X_PC = `FETCH_RESET_PC + 32'h20;
  localparam int N = 22;

  logic clock = 1'b0;
  logic reset = 1'b1;
  logic fencei = 1'b0;
  logic credit_return = 1'b0;
  fetch_pkg::redirect_t     redirect = '0;
  fetch_pkg::mem_req_t      store_req = '0;
  logic                     store_gnt;
  fetch_pkg::fetch_packet_t packet;
  logic                     packet_valid;

  entry_t      table_q [N];
  logic [31:0] ref_mem [`MEM_WORDS];
  logic [31:0] exp_pc = `FETCH_RESET_PC;
  logic [31:0] redirect_target;
  logic        redirect_req = 1'b0;
  logic        credit_mode = 1'b0;
  logic        give;
  logic [15:0] lfsr = 16'd60;
  int          pkt_count = 0;
  int          outstanding = 0;

  fetch_top fetch_top_inst (
    .clock(clock), .reset(reset), .fencei(fencei), .credit_return(credit_return),
    .redirect(redirect), .store_req(store_req), .store_gnt(store_gnt),
    .packet(packet), .packet_valid(packet_valid)
  );

  bind mem_arbiter fetch_properties arbiter_props (
    .clock(clock), .reset(reset), .refill_valid(refill_req.valid),
    .store_valid(store_req.valid), .refill_gnt(refill_gnt), .store_gnt(store_gnt),
    .packet_valid(1'b0), .credit_return(1'b0)
  );
  bind fetch_unit fetch_properties unit_props (
    .clock(clock), .reset(reset), .refill_valid(1'b0), .store_valid(1'b0),
    .refill_gnt(1'b0), .store_gnt(1'b0), .packet_valid(packet_valid),
    .credit_return(credit_return)
  );

  always #20 clock = ~clock;

  // addi-type words, never a branch, spread over the whole address
  function automatic logic [31:0] fill_word(input int i);
    logic [9:0] a;
    a = i[9:0];
    return {a, ~a, a[4:0] ^ a[9:5], 7'b0010011};
  endfunction

  // backward conditional branch taken, else fall through
  function automatic logic [31:0] predict_next(input logic [31:0] pc, input logic [31:0] w);
    logic [31:0] imm;
    imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    if (w[6:2] == 5'b11000 && w[31]) begin
      return pc + imm;
    end
    return pc + 32'd4;
  endfunction

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1);
  endtask

  // packet checker against the reference stream
  always @(negedge clock) begin
    if (!reset && packet_valid) begin
      assert (packet.pc == exp_pc)
        else report_mismatch($sformatf("pc %h expected %h", packet.pc, exp_pc));
      assert (packet.inst == ref_mem[exp_pc[11:2]])
        else report_mismatch($sformatf("inst %h expected %h at pc %h",
                                       packet.inst, ref_mem[exp_pc[11:2]], exp_pc));
      exp_pc = predict_next(exp_pc, ref_mem[exp_pc[11:2]]);
      pkt_count++;
      outstanding++;
      assert (outstanding <= `FETCH_CREDITS)
        else report_mismatch($sformatf("%0d packets outstanding", outstanding));
    end
    // the packet seen just above was still from the old stream
    if (redirect_req) begin
      exp_pc = redirect_target;
      redirect_req = 1'b0;
    end
  end

  // credit return, immediate or in lfsr order
  always @(posedge clock) begin
    #1;
    credit_return = 1'b0;
    if (!reset && outstanding > 0) begin
      give = 1'b1;
      if (credit_mode) begin
        lfsr = lfsr_step(lfsr);
        give = lfsr[0];
      end
      if (give) begin
        credit_return = 1'b1;
        outstanding--;
      end
    end
  end

  task automatic do_store(input logic [31:0] idx, input logic [31:0] w);
    store_req = '{valid: 1'b1, write: 1'b1, addr: idx, wdata: w};
    do begin
      @(negedge clock);
    end while (!store_gnt);
    ref_mem[idx[9:0]] = w;
    @(posedge clock);
    #1;
    store_req = '0;
  endtask

  task automatic apply_entry(input entry_t e);
    int target;
    case (e.kind)
      K_STORE: do_store(e.a, e.b);
      K_RUN: begin
        target = pkt_count + int'(e.a);
        while (pkt_count < target) begin
          @(posedge clock);
          #1;
        end
      end
      K_REDIRECT: begin
        redirect = '{valid: 1'b1, target: e.a};
        redirect_target = e.a;
        redirect_req = 1'b1;
        @(posedge clock);
        #1;
        redirect = '0;
      end
      K_FENCEI: begin
        fencei = 1'b1;
        @(posedge clock);
        #1;
        fencei = 1'b0;
      end
      default: credit_mode = e.a[0];
    endcase
  endtask

  // watchdog scaled by the table length
  initial begin
    repeat (N * 200) @(posedge clock);
    $display("Timeout: the fetch stream stopped before the table finished");
    $display("Test failed");
    $fatal(1);
  end

  initial begin
    table_q = '{
      '{K_CREDIT, 32'd1, 32'd0},
      '{K_RUN, 32'd24, 32'd0},
      '{K_STORE, 32'(R_PC[11:2]), 32'h0000_0463},
      '{K_STORE, 32'(R_PC[11:2] + 2), 32'hFE00_0CE3},
      '{K_REDIRECT, R_PC, 32'd0},
      '{K_RUN, 32'd9, 32'd0},
      '{K_REDIRECT, `FETCH_RESET_PC + 32'h10, 32'd0},
      '{K_RUN, 32'd6, 32'd0},
      '{K_CREDIT, 32'd0, 32'd0},
      '{K_REDIRECT, `FETCH_RESET_PC + 32'h200, 32'd0},
      '{K_RUN, 32'd4, 32'd0},
      '{K_STORE, 32'(X_PC[11:2]), 32'h00A0_0093},
      '{K_FENCEI, 32'd0, 32'd0},
      '{K_REDIRECT, X_PC, 32'd0},
      '{K_RUN, 32'd4, 32'd0},
      '{K_REDIRECT, `FETCH_RESET_PC + 32'h300, 32'd0},
      '{K_STORE, 32'd900, 32'h1234_5678},
      '{K_STORE, 32'd901, 32'h0BAD_F00D},
      '{K_RUN, 32'd12, 32'd0},
      '{K_CREDIT, 32'd1, 32'd0},
      '{K_STORE, 32'd902, 32'hCAFE_0001},
      '{K_RUN, 32'd8, 32'd0}
    };
    // backdoor fill keeps memory and reference image equal
    for (int i = 0; i < `MEM_WORDS; i++) begin
      ref_mem[i] = fill_word(i);
      fetch_top_inst.word_memory_inst.mem[i] = fill_word(i);
    end
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int i = 0; i < N; i++) begin
      apply_entry(table_q[i]);
    end
    $display("Test passed");
    $finish;
  end

endmodule
